//--- hdl/rtab_pkg.sv
// Replay table package with table size, field widths and the shared entry types
`default_nettype none

package rtab_pkg;

    // Table geometry
    localparam int RTAB_ENTRIES   = 4;
    localparam int RTAB_PTR_WIDTH = $clog2(RTAB_ENTRIES);

    // Request fields
    localparam int NLINE_WIDTH    = 10;
    localparam int PAYLOAD_WIDTH  = 16;

    // Index of one table entry
    typedef logic [RTAB_PTR_WIDTH-1:0] rtab_ptr_t;

    // One bit per table entry
    typedef logic [RTAB_ENTRIES-1:0] rtab_vec_t;

    // Cache-line index of a request
    typedef logic [NLINE_WIDTH-1:0] rtab_nline_t;

    // Default request payload
    typedef logic [PAYLOAD_WIDTH-1:0] rtab_payload_t;

endpackage

`default_nettype wire

//--- hdl/rtab_list_state.sv
// Replay table list state keeping entry flags, list links and the free-entry choice
`default_nettype none

module rtab_list_state
    import rtab_pkg::*;
(
    input  wire                 clk_i,
    input  wire                 rst_ni,

    output logic                empty_o,
    output logic                full_o,

    input  wire                 check_i,
    output logic                check_hit_o,

    input  wire                 alloc_i,
    input  wire                 alloc_link_i,
    input  wire                 alloc_mshr_hit_i,
    input  wire                 alloc_mshr_ready_i,
    output logic                alloc_we_o,
    output rtab_ptr_t           alloc_ptr_o,

    input  wire rtab_vec_t      match_check_i,
    input  wire rtab_vec_t      match_refill_i,
    input  wire                 refill_i,
    input  wire                 miss_ready_i,

    input  wire rtab_vec_t      pop_accept_i,
    input  wire                 pop_commit_i,
    input  wire rtab_ptr_t      pop_commit_ptr_i,
    input  wire                 pop_rback_i,
    input  wire rtab_ptr_t      pop_rback_ptr_i,
    input  wire                 pop_rback_mshr_hit_i,
    input  wire                 pop_rback_mshr_ready_i,

    output rtab_vec_t           ready_o,
    output rtab_vec_t           tail_o,
    output rtab_ptr_t [RTAB_ENTRIES-1:0] next_ptr_o
);

    rtab_vec_t valid_q, head_q, tail_q;
    rtab_vec_t dep_hit_q, dep_rdy_q;
    rtab_ptr_t [RTAB_ENTRIES-1:0] next_q;

    rtab_vec_t alloc_bv, commit_bv, rback_bv;
    rtab_vec_t link_tail;
    rtab_vec_t valid_set, valid_rst, head_set, head_rst, tail_set, tail_rst;
    rtab_vec_t hit_set, hit_rst, rdy_set, rdy_rst;

    // Lowest free entry, only meaningful when the table is not full
    always_comb begin
        alloc_ptr_o = '0;
        for (int i = RTAB_ENTRIES - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                alloc_ptr_o = rtab_ptr_t'(i);
            end
        end
    end

    assign alloc_we_o = alloc_i | alloc_link_i;
    assign alloc_bv   = (rtab_vec_t'(1) << alloc_ptr_o) & {RTAB_ENTRIES{alloc_we_o}};
    assign commit_bv  = (rtab_vec_t'(1) << pop_commit_ptr_i) & {RTAB_ENTRIES{pop_commit_i}};
    assign rback_bv   = (rtab_vec_t'(1) << pop_rback_ptr_i) & {RTAB_ENTRIES{pop_rback_i}};

    assign empty_o     = ~|valid_q;
    assign full_o      = &valid_q;
    assign check_hit_o = |(valid_q & match_check_i);

    // The tail of the list on the checked line gets the new entry behind it
    assign link_tail = valid_q & tail_q & match_check_i & {RTAB_ENTRIES{check_i & alloc_link_i}};

    assign valid_set = alloc_bv;
    assign valid_rst = commit_bv;

    // A new list starts with a head; a linked entry waits behind the old tail
    assign head_set = (alloc_bv & {RTAB_ENTRIES{alloc_i}}) | rback_bv;
    assign head_rst = (alloc_bv & {RTAB_ENTRIES{alloc_link_i}}) | pop_accept_i;
    assign tail_set = alloc_bv;
    assign tail_rst = link_tail;

    // A new or rolled back entry takes exactly the dependencies it arrives with
    assign hit_set = (alloc_bv & {RTAB_ENTRIES{alloc_mshr_hit_i}}) |
                     (rback_bv & {RTAB_ENTRIES{pop_rback_mshr_hit_i}});
    assign hit_rst = (match_refill_i & {RTAB_ENTRIES{refill_i}}) | alloc_bv | rback_bv;
    assign rdy_set = (alloc_bv & {RTAB_ENTRIES{alloc_mshr_ready_i}}) |
                     (rback_bv & {RTAB_ENTRIES{pop_rback_mshr_ready_i}});
    assign rdy_rst = {RTAB_ENTRIES{miss_ready_i}} | alloc_bv | rback_bv;

    assign ready_o    = valid_q & head_q & ~(dep_hit_q | dep_rdy_q);
    assign tail_o     = tail_q;
    assign next_ptr_o = next_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q   <= '0;
            head_q    <= '0;
            tail_q    <= '0;
            dep_hit_q <= '0;
            dep_rdy_q <= '0;
            next_q    <= '0;
        end else begin
            valid_q   <= (valid_q & ~valid_rst) | valid_set;
            head_q    <= (head_q & ~head_rst) | head_set;
            tail_q    <= (tail_q & ~tail_rst) | tail_set;
            dep_hit_q <= (dep_hit_q & ~hit_rst) | hit_set;
            dep_rdy_q <= (dep_rdy_q & ~rdy_rst) | rdy_set;
            for (int i = 0; i < RTAB_ENTRIES; i++) begin
                if (link_tail[i]) begin
                    next_q[i] <= alloc_ptr_o;
                end
            end
        end
    end

    // Lists on one line never fork
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        check_i |-> $onehot0(valid_q & tail_q & match_check_i))
        else $error("rtab: several tails match the checked line");

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        alloc_link_i |-> (check_i && check_hit_o))
        else $error("rtab: link without a check hit");

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        alloc_we_o |-> !full_o)
        else $error("rtab: allocation while full");

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        |pop_accept_i |=> (pop_commit_i || pop_rback_i))
        else $error("rtab: accepted pop not closed by commit or rollback");

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (pop_commit_i |-> valid_q[pop_commit_ptr_i]) and
        (pop_rback_i |-> valid_q[pop_rback_ptr_i]))
        else $error("rtab: commit or rollback of a free entry");

endmodule

`default_nettype wire

//--- hdl/rtab_payload_store.sv
// Replay table payload store holding request payloads and lines, with line compares
`default_nettype none

module rtab_payload_store
    import rtab_pkg::*;
#(
    parameter type payload_t = rtab_payload_t
) (
    input  wire                 clk_i,

    // Write port used on allocation
    input  wire                 alloc_we_i,
    input  wire rtab_ptr_t      alloc_ptr_i,
    input  wire rtab_nline_t    alloc_nline_i,
    input  wire payload_t       alloc_payload_i,

    // Line queries
    input  wire rtab_nline_t    check_nline_i,
    input  wire rtab_nline_t    refill_nline_i,
    output rtab_vec_t           match_check_o,
    output rtab_vec_t           match_refill_o,

    // Payload read port
    input  wire rtab_ptr_t      rd_ptr_i,
    output payload_t            rd_payload_o
);

    payload_t    payload_q [RTAB_ENTRIES];
    rtab_nline_t nline_q   [RTAB_ENTRIES];

    // Storage written only on allocation
    always_ff @(posedge clk_i) begin
        if (alloc_we_i) begin
            payload_q[alloc_ptr_i] <= alloc_payload_i;
            nline_q[alloc_ptr_i]   <= alloc_nline_i;
        end
    end

    // Compare every stored line against both queries
    always_comb begin
        match_check_o  = '0;
        match_refill_o = '0;
        for (int i = 0; i < RTAB_ENTRIES; i++) begin
            match_check_o[i]  = (nline_q[i] == check_nline_i);
            match_refill_o[i] = (nline_q[i] == refill_nline_i);
        end
    end

    // Payload of the entry being offered
    assign rd_payload_o = payload_q[rd_ptr_i];

endmodule

`default_nettype wire

//--- hdl/rtab_pop_sched.sv
// Replay table pop scheduler with round-robin head choice and a list-walking FSM
`default_nettype none

module rtab_pop_sched
    import rtab_pkg::*;
(
    input  wire                 clk_i,
    input  wire                 rst_ni,

    input  wire rtab_vec_t      ready_i,
    input  wire rtab_vec_t      tail_i,
    input  wire rtab_ptr_t [RTAB_ENTRIES-1:0] next_ptr_i,

    input  wire                 pop_try_i,
    input  wire                 pop_rback_i,

    output logic                pop_try_valid_o,
    output rtab_ptr_t           pop_try_ptr_o,
    output rtab_vec_t           pop_accept_o
);

    typedef enum logic [1:0] {
        POP_HEAD,
        POP_NEXT,
        POP_WAIT
    } pop_state_e;

    pop_state_e state_q, state_d;
    rtab_ptr_t  walk_ptr_q, walk_ptr_d;
    rtab_vec_t  rr_mask_q;
    rtab_vec_t  masked_req, arb_req, head_gnt;
    rtab_ptr_t  head_ptr;
    logic       accept;
    logic       head_accept;

    // Ready heads above the last grant win first
    assign masked_req = ready_i & rr_mask_q;
    assign arb_req    = (|masked_req) ? masked_req : ready_i;
    assign head_gnt   = arb_req & (~arb_req + rtab_vec_t'(1));

    always_comb begin
        head_ptr = '0;
        for (int i = 0; i < RTAB_ENTRIES; i++) begin
            if (head_gnt[i]) begin
                head_ptr = rtab_ptr_t'(i);
            end
        end
    end

    assign pop_try_valid_o = (state_q == POP_HEAD) ? |ready_i : 1'b1;
    assign pop_try_ptr_o   = (state_q == POP_HEAD) ? head_ptr : walk_ptr_q;
    assign accept          = pop_try_i & pop_try_valid_o;
    assign head_accept     = accept & (state_q == POP_HEAD);
    assign pop_accept_o    = (rtab_vec_t'(1) << pop_try_ptr_o) & {RTAB_ENTRIES{accept}};

    always_comb begin
        state_d    = state_q;
        walk_ptr_d = walk_ptr_q;
        case (state_q)
            POP_HEAD: begin
                if (accept && !tail_i[pop_try_ptr_o]) begin
                    state_d    = POP_NEXT;
                    walk_ptr_d = next_ptr_i[pop_try_ptr_o];
                end
            end
            POP_NEXT, POP_WAIT: begin
                if (state_q == POP_NEXT && pop_rback_i) begin
                    // Previous entry went back, so its list restarts from the head
                    state_d = POP_HEAD;
                end else if (accept) begin
                    if (tail_i[pop_try_ptr_o]) begin
                        state_d = POP_HEAD;
                    end else begin
                        state_d    = POP_NEXT;
                        walk_ptr_d = next_ptr_i[pop_try_ptr_o];
                    end
                end else begin
                    state_d = POP_WAIT;
                end
            end
            default: begin
                state_d = POP_HEAD;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= POP_HEAD;
            walk_ptr_q <= '0;
            rr_mask_q  <= '0;
        end else begin
            state_q    <= state_d;
            walk_ptr_q <= walk_ptr_d;
            if (head_accept) begin
                rr_mask_q <= ~(head_gnt | (head_gnt - rtab_vec_t'(1)));
            end
        end
    end

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_rback_i |-> !pop_try_i)
        else $error("rtab: pop try during rollback");

    // A rollback always closes the pop accepted one cycle earlier
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_rback_i |-> $past(|pop_accept_o))
        else $error("rtab: rollback without an accepted pop");

endmodule

`default_nettype wire

//--- hdl/rtab_top.sv
// Replay table top level joining list state, payload store and pop scheduler
`default_nettype none

module rtab_top
    import rtab_pkg::*;
#(
    parameter type payload_t = rtab_payload_t
) (
    input  wire                 clk_i,
    input  wire                 rst_ni,

    output logic                empty_o,
    output logic                full_o,

    input  wire                 check_i,
    input  wire rtab_nline_t    check_nline_i,
    output logic                check_hit_o,

    input  wire                 alloc_i,
    input  wire                 alloc_link_i,
    input  wire rtab_nline_t    alloc_nline_i,
    input  wire payload_t       alloc_payload_i,
    input  wire                 alloc_mshr_hit_i,
    input  wire                 alloc_mshr_ready_i,

    input  wire                 pop_try_i,
    output logic                pop_try_valid_o,
    output payload_t            pop_try_payload_o,
    output rtab_ptr_t           pop_try_ptr_o,

    input  wire                 pop_commit_i,
    input  wire rtab_ptr_t      pop_commit_ptr_i,

    input  wire                 pop_rback_i,
    input  wire rtab_ptr_t      pop_rback_ptr_i,
    input  wire                 pop_rback_mshr_hit_i,
    input  wire                 pop_rback_mshr_ready_i,

    input  wire                 miss_ready_i,
    input  wire                 refill_i,
    input  wire rtab_nline_t    refill_nline_i
);

    rtab_vec_t match_check, match_refill;
    rtab_vec_t ready, tail, pop_accept;
    rtab_ptr_t [RTAB_ENTRIES-1:0] next_ptr;
    rtab_ptr_t alloc_ptr;
    logic      alloc_we;

    rtab_list_state list_state_i (
        .clk_i                  (clk_i),
        .rst_ni                 (rst_ni),
        .empty_o                (empty_o),
        .full_o                 (full_o),
        .check_i                (check_i),
        .check_hit_o            (check_hit_o),
        .alloc_i                (alloc_i),
        .alloc_link_i           (alloc_link_i),
        .alloc_mshr_hit_i       (alloc_mshr_hit_i),
        .alloc_mshr_ready_i     (alloc_mshr_ready_i),
        .alloc_we_o             (alloc_we),
        .alloc_ptr_o            (alloc_ptr),
        .match_check_i          (match_check),
        .match_refill_i         (match_refill),
        .refill_i               (refill_i),
        .miss_ready_i           (miss_ready_i),
        .pop_accept_i           (pop_accept),
        .pop_commit_i           (pop_commit_i),
        .pop_commit_ptr_i       (pop_commit_ptr_i),
        .pop_rback_i            (pop_rback_i),
        .pop_rback_ptr_i        (pop_rback_ptr_i),
        .pop_rback_mshr_hit_i   (pop_rback_mshr_hit_i),
        .pop_rback_mshr_ready_i (pop_rback_mshr_ready_i),
        .ready_o                (ready),
        .tail_o                 (tail),
        .next_ptr_o             (next_ptr)
    );

    rtab_payload_store #(
        .payload_t              (payload_t)
    ) payload_store_i (
        .clk_i                  (clk_i),
        .alloc_we_i             (alloc_we),
        .alloc_ptr_i            (alloc_ptr),
        .alloc_nline_i          (alloc_nline_i),
        .alloc_payload_i        (alloc_payload_i),
        .check_nline_i          (check_nline_i),
        .refill_nline_i         (refill_nline_i),
        .match_check_o          (match_check),
        .match_refill_o         (match_refill),
        .rd_ptr_i               (pop_try_ptr_o),
        .rd_payload_o           (pop_try_payload_o)
    );

    rtab_pop_sched pop_sched_i (
        .clk_i                  (clk_i),
        .rst_ni                 (rst_ni),
        .ready_i                (ready),
        .tail_i                 (tail),
        .next_ptr_i             (next_ptr),
        .pop_try_i              (pop_try_i),
        .pop_rback_i            (pop_rback_i),
        .pop_try_valid_o        (pop_try_valid_o),
        .pop_try_ptr_o          (pop_try_ptr_o),
        .pop_accept_o           (pop_accept)
    );

endmodule

`default_nettype wire

//--- verification/rtab_tb_tasks.svh
// Replay table directed tests for allocation, dependencies, list walking and rollback

    task automatic clear_strobes();
        check_i                <= 1'b0;
        alloc_i                <= 1'b0;
        alloc_link_i           <= 1'b0;
        alloc_mshr_hit_i       <= 1'b0;
        alloc_mshr_ready_i     <= 1'b0;
        pop_try_i              <= 1'b0;
        pop_commit_i           <= 1'b0;
        pop_rback_i            <= 1'b0;
        pop_rback_mshr_hit_i   <= 1'b0;
        pop_rback_mshr_ready_i <= 1'b0;
        miss_ready_i           <= 1'b0;
        refill_i               <= 1'b0;
    endtask

    // New list, or linked behind the tail of the list on the same line
    task automatic alloc_req(input rtab_nline_t nline, input logic link, input logic hit,
                             input logic rdy, output rtab_payload_t pl);
        pl = rtab_payload_t'($random(seed));
        @(posedge clk_i);
        alloc_i            <= !link;
        alloc_link_i       <= link;
        check_i            <= link;
        check_nline_i      <= nline;
        alloc_nline_i      <= nline;
        alloc_payload_i    <= pl;
        alloc_mshr_hit_i   <= hit;
        alloc_mshr_ready_i <= rdy;
        if (link) begin
            @(negedge clk_i);
            check_eq(check_hit_o, 1, "check hit on the linked line");
        end
        @(posedge clk_i);
        clear_strobes();
    endtask

    task automatic probe_line(input rtab_nline_t nline, input logic hit, input string what);
        @(posedge clk_i);
        check_i       <= 1'b1;
        check_nline_i <= nline;
        @(negedge clk_i);
        check_eq(check_hit_o, hit, what);
        @(posedge clk_i);
        check_i <= 1'b0;
    endtask

    task automatic refill_line(input rtab_nline_t nline);
        @(posedge clk_i);
        refill_i       <= 1'b1;
        refill_nline_i <= nline;
        @(posedge clk_i);
        refill_i <= 1'b0;
    endtask

    task automatic signal_miss_ready();
        @(posedge clk_i);
        miss_ready_i <= 1'b1;
        @(posedge clk_i);
        miss_ready_i <= 1'b0;
    endtask

    task automatic expect_idle(input int cycles, input string what);
        repeat (cycles) begin
            @(negedge clk_i);
            check_eq(pop_try_valid_o, 0, what);
        end
    endtask

    // Raise the pop try and hold it until an entry is offered
    task automatic await_offer(output rtab_payload_t pl, output rtab_ptr_t ptr);
        @(posedge clk_i);
        pop_try_i <= 1'b1;
        @(negedge clk_i);
        while (!pop_try_valid_o) begin
            @(negedge clk_i);
        end
        pl  = pop_try_payload_o;
        ptr = pop_try_ptr_o;
    endtask

    task automatic pop_commit(output rtab_payload_t pl);
        rtab_ptr_t ptr;
        await_offer(pl, ptr);
        @(posedge clk_i);
        pop_try_i        <= 1'b0;
        pop_commit_i     <= 1'b1;
        pop_commit_ptr_i <= ptr;
        @(posedge clk_i);
        pop_commit_i <= 1'b0;
    endtask

    task automatic reset_values();
        @(negedge clk_i);
        check_eq(empty_o, 1, "empty after reset");
        check_eq(full_o, 0, "full after reset");
        check_eq(pop_try_valid_o, 0, "offer after reset");
    endtask

    task automatic single_request();
        rtab_payload_t stored, popped;
        alloc_req(10'h011, 1'b0, 1'b0, 1'b0, stored);
        @(negedge clk_i);
        check_eq(pop_try_valid_o, 1, "single entry offered");
        check_eq(pop_try_payload_o, stored, "single entry payload");
        // An empty table places the request in entry 0
        check_eq(pop_try_ptr_o, 0, "single entry pointer");
        pop_commit(popped);
        check_eq(popped, stored, "single entry popped payload");
        @(negedge clk_i);
        check_eq(empty_o, 1, "empty after single commit");
    endtask

    // Popped payloads must match the stored ones as a set
    task automatic fill_and_drain();
        rtab_payload_t stored[$];
        rtab_payload_t pl;
        logic found;
        int i;
        int j;
        for (i = 0; i < RTAB_ENTRIES; i++) begin
            alloc_req(rtab_nline_t'(10'h100 + i), 1'b0, 1'b0, 1'b0, pl);
            stored.push_back(pl);
        end
        @(negedge clk_i);
        check_eq(full_o, 1, "full after four allocations");
        probe_line(10'h102, 1'b1, "check of a stored line");
        probe_line(10'h2a5, 1'b0, "check of an absent line");
        for (i = 0; i < RTAB_ENTRIES; i++) begin
            pop_commit(pl);
            found = 1'b0;
            for (j = 0; j < stored.size(); j++) begin
                if (!found && stored[j] == pl) begin
                    stored.delete(j);
                    found = 1'b1;
                end
            end
            check_eq(found, 1, "popped payload was stored");
        end
        @(negedge clk_i);
        check_eq(empty_o, 1, "empty after draining a full table");
    endtask

    task automatic dependency_wait();
        rtab_payload_t stored, popped;
        alloc_req(10'h055, 1'b0, 1'b1, 1'b0, stored);
        expect_idle(2, "offer while the line miss is pending");
        refill_line(10'h056);
        expect_idle(2, "offer after a refill of another line");
        refill_line(10'h055);
        @(negedge clk_i);
        check_eq(pop_try_valid_o, 1, "offer after the refill of its line");
        pop_commit(popped);
        check_eq(popped, stored, "payload after the refill");
        alloc_req(10'h077, 1'b0, 1'b0, 1'b1, stored);
        expect_idle(2, "offer while the miss handler is busy");
        signal_miss_ready();
        @(negedge clk_i);
        check_eq(pop_try_valid_o, 1, "offer after miss ready");
        pop_commit(popped);
        check_eq(popped, stored, "payload after miss ready");
    endtask

    // B is offered right behind A while A commits
    task automatic linked_list_order();
        rtab_payload_t pl_a, pl_b, popped;
        rtab_ptr_t ptr_a, ptr_b;
        alloc_req(10'h1c3, 1'b0, 1'b0, 1'b0, pl_a);
        alloc_req(10'h1c3, 1'b1, 1'b0, 1'b0, pl_b);
        await_offer(popped, ptr_a);
        check_eq(popped, pl_a, "list head offered first");
        check_eq(ptr_a, 0, "list head pointer");
        @(posedge clk_i);
        pop_commit_i     <= 1'b1;
        pop_commit_ptr_i <= ptr_a;
        @(negedge clk_i);
        check_eq(pop_try_valid_o, 1, "second entry offered behind the head");
        check_eq(pop_try_payload_o, pl_b, "second entry payload");
        // B went to the lowest entry left free by A
        check_eq(pop_try_ptr_o, 1, "second entry pointer");
        ptr_b = pop_try_ptr_o;
        @(posedge clk_i);
        pop_try_i        <= 1'b0;
        pop_commit_ptr_i <= ptr_b;
        @(posedge clk_i);
        pop_commit_i <= 1'b0;
        @(negedge clk_i);
        check_eq(empty_o, 1, "empty after the list drained");
    endtask

    task automatic rollback_replay();
        rtab_payload_t stored, popped;
        rtab_ptr_t ptr;
        alloc_req(10'h2e0, 1'b0, 1'b0, 1'b0, stored);
        await_offer(popped, ptr);
        check_eq(popped, stored, "offer before rollback");
        @(posedge clk_i);
        pop_try_i              <= 1'b0;
        pop_rback_i            <= 1'b1;
        pop_rback_ptr_i        <= ptr;
        pop_rback_mshr_ready_i <= 1'b1;
        @(posedge clk_i);
        pop_rback_i            <= 1'b0;
        pop_rback_mshr_ready_i <= 1'b0;
        expect_idle(3, "offer while the rolled back entry waits");
        signal_miss_ready();
        @(negedge clk_i);
        check_eq(pop_try_valid_o, 1, "offer after rollback and miss ready");
        pop_commit(popped);
        check_eq(popped, stored, "replayed payload");
        @(negedge clk_i);
        check_eq(empty_o, 1, "empty after the replay commit");
    endtask

//--- verification/rtab_tb.sv
// Replay table testbench with clock, reset, timeout and the directed test sequence
`default_nettype none

module rtab_tb
    import rtab_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 2000;

    logic          clk_i = 1'b0;
    logic          rst_ni;
    logic          empty_o, full_o;
    logic          check_i, check_hit_o;
    rtab_nline_t   check_nline_i;
    logic          alloc_i, alloc_link_i, alloc_mshr_hit_i, alloc_mshr_ready_i;
    rtab_nline_t   alloc_nline_i;
    rtab_payload_t alloc_payload_i;
    logic          pop_try_i, pop_try_valid_o;
    rtab_payload_t pop_try_payload_o;
    rtab_ptr_t     pop_try_ptr_o;
    logic          pop_commit_i;
    rtab_ptr_t     pop_commit_ptr_i;
    logic          pop_rback_i, pop_rback_mshr_hit_i, pop_rback_mshr_ready_i;
    rtab_ptr_t     pop_rback_ptr_i;
    logic          miss_ready_i, refill_i;
    rtab_nline_t   refill_nline_i;

    int            seed = 77;
    int            cycle_cnt = 0;

    rtab_top rtab_top_i (.*);

    always #20 clk_i = ~clk_i;

    // Stop a run that never reaches its end
    always @(posedge clk_i) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("STATUS: FAIL");
            $fatal(1, "Simulation stopped by timeout");
        end
    end

    task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
            $display("STATUS: FAIL");
            $fatal(1, "Check failed");
        end
    endtask

    initial begin
        rst_ni           = 1'b0;
        check_nline_i    = '0;
        alloc_nline_i    = '0;
        alloc_payload_i  = '0;
        pop_commit_ptr_i = '0;
        pop_rback_ptr_i  = '0;
        refill_nline_i   = '0;
        clear_strobes();
        repeat (10) @(posedge clk_i);
        rst_ni <= 1'b1;
        reset_values();
        single_request();
        fill_and_drain();
        dependency_wait();
        linked_list_order();
        rollback_replay();
        repeat (2) @(posedge clk_i);
        $display("STATUS: PASS");
        $finish;
    end

    `include "rtab_tb_tasks.svh"

endmodule

`default_nettype wire

//--- rtab_top.f
+incdir+verification
hdl/rtab_pkg.sv
hdl/rtab_list_state.sv
hdl/rtab_payload_store.sv
hdl/rtab_pop_sched.sv
hdl/rtab_top.sv
verification/rtab_tb.sv
